//--- spu_defs.svh
`ifndef SPU_DEFS_SVH
`define SPU_DEFS_SVH

// register file
`define SPU_NUM_REGS	128
`define SPU_REG_W		128
`define SPU_REG_AW		7

// local store, indexed in quadwords
`define SPU_LS_QWORDS	64
`define SPU_LS_AW		6

// instruction fields
`define SPU_INSTR_W		32
`define SPU_IMM_W		18
`define SPU_OP_RI18_W	7
`define SPU_OP_RI10_W	8
`define SPU_OP_RR_W		11

// APB debug port, byte addressed
`define SPU_APB_AW		11

`endif

//--- spu_pkg.sv
`default_nettype none

`include "spu_defs.svh"

package spu_pkg;

	typedef enum logic [3:0] {
		EV_NOP,
		EV_A,
		EV_AH,
		EV_SF,
		EV_AND,
		EV_OR,
		EV_XOR,
		EV_NAND,
		EV_CEQ,
		EV_AI,
		EV_ANDI,
		EV_ORI,
		EV_ILA
	} even_op_e;

	typedef enum logic [2:0] {
		OD_LNOP,
		OD_LQD,
		OD_STQD,
		OD_ROTQBYI,
		OD_SHLQBYI
	} odd_op_e;

	// one decoded instruction for the even slot
	typedef struct packed {
		even_op_e					op;
		logic [0:`SPU_REG_AW-1]		rt_addr;
		logic [0:`SPU_REG_AW-1]		ra_addr;
		logic [0:`SPU_REG_AW-1]		rb_addr;
		logic [0:`SPU_IMM_W-1]		imm;		// raw field, right-justified
		logic						reg_write;
	} even_issue_t;

	typedef struct packed {
		odd_op_e					op;
		logic [0:`SPU_REG_AW-1]		rt_addr;
		logic [0:`SPU_REG_AW-1]		ra_addr;
		logic [0:`SPU_REG_AW-1]		rb_addr;	// rt field for stqd
		logic [0:`SPU_IMM_W-1]		imm;
		logic						reg_write;
	} odd_issue_t;

	typedef struct packed {
		logic						valid;
		logic [0:`SPU_REG_AW-1]		addr;
		logic [0:`SPU_REG_W-1]		data;
	} wb_t;

endpackage

`default_nettype wire

//--- spu_decode.sv
`default_nettype none

`include "spu_defs.svh"

module spu_decode import spu_pkg::*; (
	input  logic [0:`SPU_INSTR_W-1]	instr_even,
	input  logic [0:`SPU_INSTR_W-1]	instr_odd,
	output even_issue_t				even_issue,
	output odd_issue_t				odd_issue
);

	// even slot, 7 bit RI18 first, then RI10, then RR
	always_comb begin
		even_issue = '0;
		even_issue.op = EV_NOP;
		even_issue.rt_addr = instr_even[25:31];
		even_issue.ra_addr = instr_even[18:24];
		even_issue.rb_addr = instr_even[11:17];
		if (instr_even[0:`SPU_OP_RI18_W-1] == 7'b0100001) begin	// ila
			even_issue.op = EV_ILA;
			even_issue.imm = instr_even[7:24];
		end
		else begin
			even_issue.imm = {8'b0, instr_even[8:17]};		// i10
			case (instr_even[0:`SPU_OP_RI10_W-1])
				8'b00011100 : even_issue.op = EV_AI;
				8'b00010100 : even_issue.op = EV_ANDI;
				8'b00000100 : even_issue.op = EV_ORI;
				default : begin
					case (instr_even[0:`SPU_OP_RR_W-1])
						11'b00011000000 : even_issue.op = EV_A;
						11'b00011001000 : even_issue.op = EV_AH;
						11'b00001000000 : even_issue.op = EV_SF;
						11'b00011000001 : even_issue.op = EV_AND;
						11'b00001000001 : even_issue.op = EV_OR;
						11'b01001000001 : even_issue.op = EV_XOR;
						11'b00011001001 : even_issue.op = EV_NAND;
						11'b01111000000 : even_issue.op = EV_CEQ;
						default : even_issue.op = EV_NOP;	// nop and unknown words
					endcase
				end
			endcase
		end
		even_issue.reg_write = (even_issue.op != EV_NOP);
	end

	// odd slot, RI10 memory ops first, then RR and RI7
	always_comb begin
		odd_issue = '0;
		odd_issue.op = OD_LNOP;
		odd_issue.rt_addr = instr_odd[25:31];
		odd_issue.ra_addr = instr_odd[18:24];
		odd_issue.rb_addr = instr_odd[11:17];
		odd_issue.imm = {8'b0, instr_odd[8:17]};
		case (instr_odd[0:`SPU_OP_RI10_W-1])
			8'b00110100 : begin			// lqd
				odd_issue.op = OD_LQD;
				odd_issue.reg_write = 1'b1;
			end
			8'b00100100 : begin			// stqd
				odd_issue.op = OD_STQD;
				odd_issue.rb_addr = instr_odd[25:31];	// store data on port b
			end
			default : begin
				odd_issue.imm = {11'b0, instr_odd[11:17]};	// i7
				case (instr_odd[0:`SPU_OP_RR_W-1])
					11'b00111111100 : begin		// rotqbyi
						odd_issue.op = OD_ROTQBYI;
						odd_issue.reg_write = 1'b1;
					end
					11'b00111111111 : begin		// shlqbyi
						odd_issue.op = OD_SHLQBYI;
						odd_issue.reg_write = 1'b1;
					end
					default : odd_issue.op = OD_LNOP;	// lnop and unknown words
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

//--- spu_regfile.sv
`default_nettype none

`include "spu_defs.svh"

module spu_regfile import spu_pkg::*; (
	input  logic					clk,
	input  logic					rst_n,
	input  even_issue_t				even_issue,
	input  odd_issue_t				odd_issue,
	output logic [0:`SPU_REG_W-1]	ra_even,
	output logic [0:`SPU_REG_W-1]	rb_even,
	output logic [0:`SPU_REG_W-1]	rc_even,
	output logic [0:`SPU_REG_W-1]	ra_odd,
	output logic [0:`SPU_REG_W-1]	rb_odd,
	input  wb_t						wb_even,
	input  wb_t						wb_odd,
	input  logic					psel,
	input  logic					penable,
	input  logic					pwrite,
	input  logic [`SPU_APB_AW-1:0]	paddr,
	input  logic [31:0]				pwdata,
	output logic [31:0]				prdata,
	output logic					pready
);

	logic [0:`SPU_REG_W-1]		regs [`SPU_NUM_REGS];
	logic [0:`SPU_REG_AW-1]		apb_reg;
	logic [1:0]					apb_word;		// word 0 is the msw
	logic						apb_wr;

	assign ra_even = regs[even_issue.ra_addr];
	assign rb_even = regs[even_issue.rb_addr];
	assign rc_even = regs[even_issue.rt_addr];	// rc field sits where rt is for rrr
	assign ra_odd = regs[odd_issue.ra_addr];
	assign rb_odd = regs[odd_issue.rb_addr];

	assign apb_reg = paddr[10:4];
	assign apb_word = paddr[3:2];
	assign pready = 1'b1;
	assign prdata = regs[apb_reg][{apb_word, 5'b0} +: 32];

	// host write loses to any writeback of the same register
	assign apb_wr = psel && penable && pwrite
		&& !(wb_even.valid && wb_even.addr == apb_reg)
		&& !(wb_odd.valid && wb_odd.addr == apb_reg);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `SPU_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else begin
			if (apb_wr)
				regs[apb_reg][{apb_word, 5'b0} +: 32] <= pwdata;
			if (wb_even.valid)
				regs[wb_even.addr] <= wb_even.data;
			if (wb_odd.valid)
				regs[wb_odd.addr] <= wb_odd.data;
		end
	end

	// software spacing must keep the two pipes off the same target
	a_wb_no_clash : assert property (@(posedge clk) disable iff (!rst_n)
		(wb_even.valid && wb_odd.valid) |-> (wb_even.addr != wb_odd.addr));

endmodule

`default_nettype wire

//--- spu_even_pipe.sv
`default_nettype none

`include "spu_defs.svh"

module spu_even_pipe import spu_pkg::*; (
	input  logic					clk,
	input  logic					rst_n,
	input  even_issue_t				issue,
	input  logic [0:`SPU_REG_W-1]	ra,
	input  logic [0:`SPU_REG_W-1]	rb,
	output wb_t						wb
);

	even_op_e					ex_op;
	logic						ex_wr;
	logic [0:`SPU_REG_AW-1]		ex_rt;
	logic [0:`SPU_IMM_W-1]		ex_imm;
	logic [0:`SPU_REG_W-1]		ex_ra, ex_rb;
	logic [31:0]				simm;
	logic [0:`SPU_REG_W-1]		res;

	// stage 1 operand capture
	always_ff @(posedge clk) begin
		ex_rt <= issue.rt_addr;
		ex_imm <= issue.imm;
		ex_ra <= ra;
		ex_rb <= rb;
		if (!rst_n) begin
			ex_op <= EV_NOP;
			ex_wr <= 1'b0;
		end
		else begin
			ex_op <= issue.op;
			ex_wr <= issue.reg_write;
		end
	end

	assign simm = {{22{ex_imm[8]}}, ex_imm[8:17]};	// i10 sign extended

	// stage 2, one 32 bit slot at a time
	always_comb begin : calc
		logic [31:0] a_w, b_w, r_w;
		res = '0;
		for (int i = 0; i < 4; i++) begin
			a_w = ex_ra[i*32 +: 32];
			b_w = ex_rb[i*32 +: 32];
			case (ex_op)
				EV_A    : r_w = a_w + b_w;
				EV_AH   : r_w = {a_w[31:16] + b_w[31:16], a_w[15:0] + b_w[15:0]};
				EV_SF   : r_w = b_w - a_w;
				EV_AND  : r_w = a_w & b_w;
				EV_OR   : r_w = a_w | b_w;
				EV_XOR  : r_w = a_w ^ b_w;
				EV_NAND : r_w = ~(a_w & b_w);
				EV_CEQ  : r_w = (a_w == b_w) ? 32'hffff_ffff : 32'h0;
				EV_AI   : r_w = a_w + simm;
				EV_ANDI : r_w = a_w & simm;
				EV_ORI  : r_w = a_w | simm;
				EV_ILA  : r_w = {14'b0, ex_imm};
				default : r_w = 32'h0;
			endcase
			res[i*32 +: 32] = r_w;
		end
	end

	always_ff @(posedge clk) begin
		wb.addr <= ex_rt;
		wb.data <= res;
		if (!rst_n)
			wb.valid <= 1'b0;
		else
			wb.valid <= ex_wr;
	end

	// decode must never mark a nop as writing
	a_no_nop_wb : assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> $past(ex_op) != EV_NOP);

endmodule

`default_nettype wire

//--- spu_odd_pipe.sv
`default_nettype none

`include "spu_defs.svh"

module spu_odd_pipe import spu_pkg::*; (
	input  logic					clk,
	input  logic					rst_n,
	input  odd_issue_t				issue,
	input  logic [0:`SPU_REG_W-1]	ra,
	input  logic [0:`SPU_REG_W-1]	rb,
	output wb_t						wb
);

	odd_op_e					ex_op;
	logic						ex_wr;
	logic [0:`SPU_REG_AW-1]		ex_rt;
	logic [0:`SPU_IMM_W-1]		ex_imm;
	logic [0:`SPU_REG_W-1]		ex_ra, ex_rb;

	logic [0:`SPU_REG_W-1]		ls [`SPU_LS_QWORDS];	// local store
	logic [31:0]				ea;
	logic [`SPU_LS_AW-1:0]		ls_idx;
	logic [3:0]					rot_cnt;
	logic [6:0]					shl_cnt;
	logic [0:`SPU_REG_W-1]		rot_q, shl_q, res;

	always_ff @(posedge clk) begin
		ex_rt <= issue.rt_addr;
		ex_imm <= issue.imm;
		ex_ra <= ra;
		ex_rb <= rb;
		if (!rst_n) begin
			ex_op <= OD_LNOP;
			ex_wr <= 1'b0;
		end
		else begin
			ex_op <= issue.op;
			ex_wr <= issue.reg_write;
		end
	end

	// byte address from preferred word plus i10 scaled to quadwords
	assign ea = ex_ra[0:31] + {{18{ex_imm[8]}}, ex_imm[8:17], 4'b0};
	assign ls_idx = ea[`SPU_LS_AW+3:4];	// quadword index modulo the store size

	always_ff @(posedge clk) begin
		if (ex_op == OD_STQD)
			ls[ls_idx] <= ex_rb;
	end

	// byte 0 is the leftmost, so a left shift moves bytes toward 0
	assign rot_cnt = ex_imm[14:17];
	assign shl_cnt = ex_imm[11:17];
	assign rot_q = (ex_ra << {rot_cnt, 3'b0}) | (ex_ra >> (8'd128 - {rot_cnt, 3'b0}));
	assign shl_q = (shl_cnt > 7'd15) ? '0 : ex_ra << {shl_cnt[3:0], 3'b0};

	always_comb begin
		case (ex_op)
			OD_LQD     : res = ls[ls_idx];
			OD_ROTQBYI : res = rot_q;
			OD_SHLQBYI : res = shl_q;
			default    : res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		wb.addr <= ex_rt;
		wb.data <= res;
		if (!rst_n)
			wb.valid <= 1'b0;
		else
			wb.valid <= ex_wr;
	end

	// a load or store needs a resolved local store address
	a_ls_idx_known : assert property (@(posedge clk) disable iff (!rst_n)
		(ex_op == OD_LQD || ex_op == OD_STQD) |-> !$isunknown(ls_idx));

endmodule

`default_nettype wire

//--- spu_core.sv
`default_nettype none

`include "spu_defs.svh"

module spu_core import spu_pkg::*; (
	input  logic					clk,
	input  logic					rst_n,
	input  logic [0:`SPU_INSTR_W-1]	instr_even,		// one pair per cycle
	input  logic [0:`SPU_INSTR_W-1]	instr_odd,
	input  logic					psel,
	input  logic					penable,
	input  logic					pwrite,
	input  logic [`SPU_APB_AW-1:0]	paddr,
	input  logic [31:0]				pwdata,
	output logic [31:0]				prdata,
	output logic					pready
);

	even_issue_t				even_issue;
	odd_issue_t					odd_issue;
	logic [0:`SPU_REG_W-1]		ra_even, rb_even, ra_odd, rb_odd;
	wb_t						wb_even, wb_odd;

	spu_decode dec (.instr_even(instr_even), .instr_odd(instr_odd),
		.even_issue(even_issue), .odd_issue(odd_issue));

	spu_regfile rf (.clk(clk), .rst_n(rst_n), .even_issue(even_issue), .odd_issue(odd_issue),
		.ra_even(ra_even), .rb_even(rb_even), .rc_even(), .ra_odd(ra_odd), .rb_odd(rb_odd),
		.wb_even(wb_even), .wb_odd(wb_odd), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready));

	spu_even_pipe ev (.clk(clk), .rst_n(rst_n), .issue(even_issue), .ra(ra_even),
		.rb(rb_even), .wb(wb_even));

	spu_odd_pipe od (.clk(clk), .rst_n(rst_n), .issue(odd_issue), .ra(ra_odd),
		.rb(rb_odd), .wb(wb_odd));

endmodule

`default_nettype wire

//--- spu_core_tb.sv
`default_nettype none

`include "spu_defs.svh"

module spu_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int APB_TIMEOUT = 16;

	localparam logic [10:0] OP_A = 11'b00011000000;
	localparam logic [10:0] OP_AH = 11'b00011001000;
	localparam logic [10:0] OP_SF = 11'b00001000000;
	localparam logic [10:0] OP_AND = 11'b00011000001;
	localparam logic [10:0] OP_OR = 11'b00001000001;
	localparam logic [10:0] OP_XOR = 11'b01001000001;
	localparam logic [10:0] OP_NAND = 11'b00011001001;
	localparam logic [10:0] OP_CEQ = 11'b01111000000;
	localparam logic [10:0] OP_ROTQBYI = 11'b00111111100;
	localparam logic [10:0] OP_SHLQBYI = 11'b00111111111;
	localparam logic [7:0] OP_AI = 8'b00011100;
	localparam logic [7:0] OP_ANDI = 8'b00010100;
	localparam logic [7:0] OP_ORI = 8'b00000100;
	localparam logic [7:0] OP_LQD = 8'b00110100;
	localparam logic [7:0] OP_STQD = 8'b00100100;
	localparam logic [6:0] OP_ILA = 7'b0100001;
	localparam logic [31:0] NOP_E = {11'b01000000001, 21'b0};
	localparam logic [31:0] LNOP_O = {11'b00000000001, 21'b0};
	localparam logic [31:0] BAD_WORD = {11'b11111111111, 21'b0};	// matches no prefix

	logic				clk;
	logic				rst_n;
	logic [31:0]		instr_even, instr_odd;
	logic				psel, penable, pwrite;
	logic [`SPU_APB_AW-1:0]	paddr;
	logic [31:0]		pwdata, prdata;
	logic				pready;

	logic [127:0]		model [128];	// expected register contents, word 0 in [127:96]
	logic [31:0]		rng_state = 32'h4439ec7b;

	spu_core dut_i (.clk(clk), .rst_n(rst_n), .instr_even(instr_even), .instr_odd(instr_odd),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic [127:0] rand128();
		return {xorshift32(), xorshift32(), xorshift32(), xorshift32()};
	endfunction

	function automatic logic [31:0] enc_rr(logic [10:0] op, logic [6:0] rb, ra, rt);
		return {op, rb, ra, rt};
	endfunction

	function automatic logic [31:0] enc_ri7(logic [10:0] op, logic [6:0] i7, ra, rt);
		return {op, i7, ra, rt};
	endfunction

	function automatic logic [31:0] enc_ri10(logic [7:0] op, logic [9:0] i10, logic [6:0] ra, rt);
		return {op, i10, ra, rt};
	endfunction

	// per-word result of an even op, immediates as i10 or i18
	function automatic logic [127:0] even_model(string op, logic [127:0] a, b, logic [17:0] imm);
		logic [31:0] aw, bw, k, r;
		logic [127:0] res;
		k = {{22{imm[9]}}, imm[9:0]};
		for (int w = 0; w < 4; w++) begin
			aw = a[32*w +: 32];
			bw = b[32*w +: 32];
			case (op)
				"a" : r = aw + bw;
				"ah" : begin
					r[31:16] = aw[31:16] + bw[31:16];
					r[15:0] = aw[15:0] + bw[15:0];
				end
				"sf" : r = bw - aw;
				"and" : r = aw & bw;
				"or" : r = aw | bw;
				"xor" : r = aw ^ bw;
				"nand" : r = ~(aw & bw);
				"ceq" : r = (aw == bw) ? '1 : '0;
				"ai" : r = aw + k;
				"andi" : r = aw & k;
				"ori" : r = aw | k;
				"ila" : r = {14'b0, imm};
				default : r = 'x;
			endcase
			res[32*w +: 32] = r;
		end
		return res;
	endfunction

	// byte 0 is the leftmost byte; a shift moves bytes toward it
	function automatic logic [127:0] quad_bytes(logic [127:0] x, int n, bit rotate);
		logic [127:0] r;
		int src;
		r = '0;
		for (int i = 0; i < 16; i++) begin
			src = rotate ? (i + n) % 16 : i + n;
			if (src < 16)
				r[127-8*i -: 8] = x[127-8*src -: 8];
		end
		return r;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(string name, logic [127:0] got, logic [127:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic apb_access(bit wr, logic [`SPU_APB_AW-1:0] addr, logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		n = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			if (n == APB_TIMEOUT)
				abort_run("APB transfer never saw pready within the timeout");
			n++;
			@(negedge clk);
			#1;
		end
		rdata = prdata;		// access phase, before the edge
		@(posedge clk);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(logic [6:0] r, logic [1:0] w, logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, {r, w, 2'b00}, data, unused);
	endtask

	task automatic apb_read(logic [6:0] r, logic [1:0] w, output logic [31:0] data);
		apb_access(1'b0, {r, w, 2'b00}, 32'h0, data);
	endtask

	task automatic write_reg128(logic [6:0] r, logic [127:0] val);
		for (int w = 0; w < 4; w++)
			apb_write(r, w[1:0], val[127-32*w -: 32]);
		model[r] = val;
	endtask

	task automatic read_reg128(logic [6:0] r, output logic [127:0] val);
		logic [31:0] d;
		for (int w = 0; w < 4; w++) begin
			apb_read(r, w[1:0], d);
			val[127-32*w -: 32] = d;
		end
	endtask

	task automatic verify_reg(logic [6:0] r);
		logic [127:0] v;
		read_reg128(r, v);
		check($sformatf("r%0d", r), v, model[r]);
	endtask

	task automatic issue_pair(logic [31:0] e, logic [31:0] o);
		@(negedge clk);
		instr_even = e;
		instr_odd = o;
	endtask

	task automatic nops(int n);
		repeat (n) issue_pair(NOP_E, LNOP_O);
	endtask

	task automatic test_reset();
		logic [31:0] d, v;
		verify_reg(0);
		verify_reg(9);
		verify_reg(127);
		v = xorshift32();
		apb_write(6, 1, v);
		model[6][95:64] = v;
		apb_read(6, 1, d);
		check("r6 word 1", d, v);
	endtask

	task automatic test_even_arith();
		write_reg128(1, rand128());
		write_reg128(2, rand128());
		issue_pair(enc_rr(OP_A, 2, 1, 10), LNOP_O);
		model[10] = even_model("a", model[1], model[2], 0);
		issue_pair(enc_rr(OP_AH, 2, 1, 11), LNOP_O);
		model[11] = even_model("ah", model[1], model[2], 0);
		issue_pair(enc_rr(OP_SF, 2, 1, 12), LNOP_O);	// r2 minus r1
		model[12] = even_model("sf", model[1], model[2], 0);
		issue_pair(enc_ri10(OP_AI, 10'h3f9, 1, 13), LNOP_O);
		model[13] = even_model("ai", model[1], 0, 18'h003f9);
		issue_pair({OP_ILA, 18'h2abcd, 7'd14}, LNOP_O);
		model[14] = even_model("ila", 0, 0, 18'h2abcd);
		nops(4);
		for (int r = 10; r <= 14; r++)
			verify_reg(r);
	endtask

	task automatic test_logic_compare();
		logic [127:0] m;
		m = model[1];
		write_reg128(3, {m[127:96], ~m[95:64], m[63:32], m[31:0] ^ 32'h1});
		issue_pair(enc_rr(OP_AND, 2, 1, 15), LNOP_O);
		issue_pair(enc_rr(OP_OR, 2, 1, 16), LNOP_O);
		issue_pair(enc_rr(OP_XOR, 2, 1, 17), LNOP_O);
		issue_pair(enc_rr(OP_NAND, 2, 1, 18), LNOP_O);
		issue_pair(enc_ri10(OP_ANDI, 10'h155, 1, 19), LNOP_O);
		issue_pair(enc_ri10(OP_ORI, 10'h2aa, 2, 20), LNOP_O);	// negative i10
		issue_pair(enc_rr(OP_CEQ, 3, 1, 21), LNOP_O);
		issue_pair(enc_rr(OP_CEQ, 1, 1, 22), LNOP_O);
		model[15] = even_model("and", model[1], model[2], 0);
		model[16] = even_model("or", model[1], model[2], 0);
		model[17] = even_model("xor", model[1], model[2], 0);
		model[18] = even_model("nand", model[1], model[2], 0);
		model[19] = even_model("andi", model[1], 0, 18'h00155);
		model[20] = even_model("ori", model[2], 0, 18'h002aa);
		model[21] = even_model("ceq", model[1], model[3], 0);
		model[22] = even_model("ceq", model[1], model[1], 0);
		nops(4);
		for (int r = 15; r <= 22; r++)
			verify_reg(r);
	endtask

	task automatic test_odd_pipe();
		write_reg128(4, rand128());
		write_reg128(5, rand128());
		issue_pair(NOP_E, enc_ri10(OP_STQD, 10'h3, 5, 4));	// rt field is the store data
		nops(2);
		issue_pair(NOP_E, enc_ri10(OP_LQD, 10'h3, 5, 23));
		model[23] = model[4];
		issue_pair(NOP_E, enc_ri7(OP_ROTQBYI, 0, 4, 24));
		issue_pair(NOP_E, enc_ri7(OP_ROTQBYI, 5, 4, 25));
		issue_pair(NOP_E, enc_ri7(OP_ROTQBYI, 15, 4, 26));
		issue_pair(NOP_E, enc_ri7(OP_SHLQBYI, 0, 4, 27));
		issue_pair(NOP_E, enc_ri7(OP_SHLQBYI, 5, 4, 28));
		issue_pair(NOP_E, enc_ri7(OP_SHLQBYI, 15, 4, 29));
		issue_pair(NOP_E, enc_ri7(OP_SHLQBYI, 16, 4, 30));
		model[24] = quad_bytes(model[4], 0, 1);
		model[25] = quad_bytes(model[4], 5, 1);
		model[26] = quad_bytes(model[4], 15, 1);
		model[27] = quad_bytes(model[4], 0, 0);
		model[28] = quad_bytes(model[4], 5, 0);
		model[29] = quad_bytes(model[4], 15, 0);
		model[30] = quad_bytes(model[4], 16, 0);
		nops(4);
		for (int r = 23; r <= 30; r++)
			verify_reg(r);
	endtask

	task automatic test_dual_and_unknown();
		write_reg128(40, rand128());
		issue_pair(enc_rr(OP_A, 2, 1, 31), enc_ri7(OP_ROTQBYI, 5, 4, 32));
		model[31] = even_model("a", model[1], model[2], 0);
		model[32] = quad_bytes(model[4], 5, 1);
		issue_pair(NOP_E | 32'd40, LNOP_O | 32'd40);	// rt fields aim at the marked reg
		issue_pair(BAD_WORD | 32'd40, BAD_WORD | 32'd40);
		nops(4);
		verify_reg(31);
		verify_reg(32);
		verify_reg(40);
	endtask

	initial begin
		rst_n = 1'b0;
		instr_even = NOP_E;
		instr_odd = LNOP_O;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < 128; i++)
			model[i] = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_even_arith();
		test_logic_compare();
		test_odd_pipe();
		test_dual_and_unknown();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- spu.f
+incdir+.
spu_pkg.sv
spu_decode.sv
spu_regfile.sv
spu_even_pipe.sv
spu_odd_pipe.sv
spu_core.sv
spu_core_tb.sv
